// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // virtual address as seen by the fetch PC
    typedef logic [31:0] vaddr_t;

    // fetch exception codes
    typedef enum logic [1:0] {
        exc_none    = 2'd0,
        exc_addr    = 2'd1,  // misaligned pc
        exc_refill  = 2'd2,  // no tlb entry for the page
        exc_invalid = 2'd3   // entry found but marked invalid
    } except_e;

    // one redirect request
    typedef struct packed {
        logic   valid;
        vaddr_t target;
    } redirect_src_t;

    // all redirect sources, highest priority first
    typedef struct packed {
        redirect_src_t exc;         // exception vector
        redirect_src_t eret;        // return from exception
        redirect_src_t refetch;
        redirect_src_t correction;  // branch fix-up
    } redirect_t;

    // one word leaving the fetch stage
    typedef struct packed {
        logic        valid;
        vaddr_t      pc;
        logic [31:0] instr;  // zero on exception
        except_e     exc;
    } fetch_result_t;

    // boot rom entry in kseg1
    localparam vaddr_t reset_vector = 32'hBFC0_0000;

endpackage

// ==== hw/mmu_pkg.sv ====
package mmu_pkg;

    // physical address after translation
    typedef logic [31:0] paddr_t;

    // one tlb buffer line, 4 KiB pages
    typedef struct packed {
        logic [19:0] vpn;
        logic [19:0] pfn;
        logic        valid;
        logic        cached;
    } tlb_entry_t;

    // translation outcome for the current pc
    typedef struct packed {
        paddr_t             paddr;
        logic               cached;
        fetch_pkg::except_e exc;
    } xlate_t;

    // wishbone classic master request
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
        logic [3:0]  sel;  // byte lanes, always full word here
    } wb_req_t;

    // segment decode on the top address bits
    localparam logic [2:0] seg_kseg0 = 3'b100;  // cached, unmapped
    localparam logic [2:0] seg_kseg1 = 3'b101;  // uncached, unmapped

endpackage

// ==== hw/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fetch_pkg::redirect_t redirect,
    input  logic                 advance,
    output fetch_pkg::vaddr_t    pc,
    output logic                 flush
);
    import fetch_pkg::*;

    logic   take;    // some redirect is requested this cycle
    logic   step;    // sequential advance from the fetch port
    vaddr_t target;

    // fixed priority pick of the next pc
    always_comb begin
        take   = 1'b1;
        target = pc + 32'd4;
        if (redirect.exc.valid) begin
            target = redirect.exc.target;
        end else if (redirect.eret.valid) begin
            target = redirect.eret.target;
        end else if (redirect.refetch.valid) begin
            target = redirect.refetch.target;
        end else if (redirect.correction.valid) begin
            target = redirect.correction.target;
        end else begin
            take = 1'b0;  // plain pc + 4
        end
    end

    // an advance seen while flush is high belongs to the old path
    assign step = advance && !flush;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc    <= reset_vector;
            flush <= 1'b0;
        end else begin
            flush <= take;  // one cycle after the redirect edge
            if (take || step) begin
                pc <= target;
            end
        end
    end

endmodule

// ==== hw/itlb.sv ====
`timescale 1ns/1ps

module itlb #(
    parameter int tlb_entries = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  fetch_pkg::vaddr_t   pc,
    input  logic                tlb_write,
    input  mmu_pkg::tlb_entry_t tlb_wdata,
    output mmu_pkg::xlate_t     xlate
);
    import fetch_pkg::*;
    import mmu_pkg::*;

    localparam int idx_w = (tlb_entries > 1) ? $clog2(tlb_entries) : 1;

    tlb_entry_t             entry [tlb_entries];
    logic [tlb_entries-1:0] slot_used;  // slot holds a written entry
    logic [idx_w-1:0]       victim;     // round robin replacement pointer

    logic                   wr_hit;
    logic [idx_w-1:0]       wr_idx;
    logic                   lk_hit;
    logic [idx_w-1:0]       lk_idx;
    logic                   unmapped;

    // refill goes over a matching vpn, else to the victim
    always_comb begin
        wr_hit = 1'b0;
        wr_idx = victim;
        for (int i = 0; i < tlb_entries; i++) begin
            if (!wr_hit && slot_used[i] && entry[i].vpn == tlb_wdata.vpn) begin
                wr_hit = 1'b1;
                wr_idx = idx_w'(i);
            end
        end
    end

    // lookup on the fetch pc, first match wins
    always_comb begin
        lk_hit = 1'b0;
        lk_idx = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            if (!lk_hit && slot_used[i] && entry[i].vpn == pc[31:12]) begin
                lk_hit = 1'b1;
                lk_idx = idx_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_write) begin
            entry[wr_idx] <= tlb_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_used <= '0;
            victim    <= '0;
        end else if (tlb_write) begin
            slot_used[wr_idx] <= 1'b1;
            if (!wr_hit) begin
                victim <= (victim == idx_w'(tlb_entries - 1)) ? '0 : victim + 1'b1;
            end
        end
    end

    // kseg0 and kseg1 bypass the buffer
    assign unmapped = (pc[31:29] == seg_kseg0) || (pc[31:29] == seg_kseg1);

    always_comb begin
        xlate.paddr  = {3'b000, pc[28:0]};
        xlate.cached = (pc[31:29] == seg_kseg0);
        xlate.exc    = exc_none;
        if (pc[1:0] != 2'b00) begin
            xlate.exc = exc_addr;  // beats any tlb outcome
        end else if (!unmapped) begin
            xlate.cached = 1'b0;
            if (!lk_hit) begin
                xlate.exc = exc_refill;
            end else if (!entry[lk_idx].valid) begin
                xlate.exc = exc_invalid;
            end else begin
                xlate.paddr  = {entry[lk_idx].pfn, pc[11:0]};
                xlate.cached = entry[lk_idx].cached;
            end
        end
    end

endmodule

// ==== hw/fetch_port.sv ====
`timescale 1ns/1ps

module fetch_port (
    input  logic                     clk,
    input  logic                     rst_n,
    input  fetch_pkg::vaddr_t        pc,
    input  mmu_pkg::xlate_t          xlate,
    input  logic                     flush,
    input  logic                     hold,
    output mmu_pkg::wb_req_t         wb,
    input  logic [31:0]              wb_dat,
    input  logic                     wb_ack,
    output fetch_pkg::fetch_result_t result,
    output logic                     result_cached,
    output logic                     advance
);
    import fetch_pkg::*;
    import mmu_pkg::*;

    typedef enum logic {
        st_idle,
        st_busy
    } state_e;

    state_e      state;
    logic        stale;       // word in flight belongs to a dropped path
    paddr_t      req_adr;
    vaddr_t      req_pc;
    logic        req_cached;

    logic        res_valid;
    vaddr_t      res_pc;
    logic [31:0] res_instr;
    except_e     res_exc;
    logic        res_cached;

    logic        start_ok;
    logic        start_bus;
    logic        start_exc;
    logic        deliver;

    // wait one cycle after a result so pc_gen can step first
    assign start_ok  = (state == st_idle) && !hold && !res_valid;
    assign start_bus = start_ok && (xlate.exc == exc_none);
    assign start_exc = start_ok && (xlate.exc != exc_none);
    assign deliver   = (state == st_busy) && wb_ack && !stale && !flush;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            stale     <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= start_exc || deliver;  // single cycle pulse
            case (state)
                st_idle: begin
                    if (start_bus) begin
                        state <= st_busy;
                        stale <= 1'b0;
                    end
                end
                st_busy: begin
                    if (flush) begin
                        stale <= 1'b1;  // keep the cycle open, drop the word
                    end
                    if (wb_ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_bus) begin
            req_adr    <= xlate.paddr;
            req_pc     <= pc;
            req_cached <= xlate.cached;
        end
        if (start_exc) begin
            res_pc     <= pc;
            res_instr  <= '0;
            res_exc    <= xlate.exc;
            res_cached <= xlate.cached;
        end else if (deliver) begin
            res_pc     <= req_pc;
            res_instr  <= wb_dat;
            res_exc    <= exc_none;
            res_cached <= req_cached;
        end
    end

    // request held steady for the whole busy state
    assign wb.cyc = (state == st_busy);
    assign wb.stb = (state == st_busy);
    assign wb.adr = req_adr;
    assign wb.sel = 4'hF;

    assign result.valid  = res_valid;
    assign result.pc     = res_pc;
    assign result.instr  = res_instr;
    assign result.exc    = res_exc;
    assign result_cached = res_cached;
    assign advance       = res_valid;  // every delivered result consumes the pc

endmodule

// ==== hw/prefetch_top.sv ====
`timescale 1ns/1ps

module prefetch_top #(
    parameter int tlb_entries = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  fetch_pkg::redirect_t     redirect,
    input  logic                     hold,
    input  logic                     tlb_write,
    input  mmu_pkg::tlb_entry_t      tlb_wdata,
    output mmu_pkg::wb_req_t         wb,
    input  logic [31:0]              wb_dat,
    input  logic                     wb_ack,
    output fetch_pkg::fetch_result_t result,
    output logic                     result_cached
);
    import fetch_pkg::*;
    import mmu_pkg::*;

    vaddr_t pc;
    xlate_t xlate;    // combinational from pc
    logic   advance;  // current pc consumed
    logic   flush;    // pc was just redirected

    pc_gen u_pc_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .redirect (redirect),
        .advance  (advance),
        .pc       (pc),
        .flush    (flush)
    );

    itlb #(
        .tlb_entries (tlb_entries)
    ) u_itlb (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc        (pc),
        .tlb_write (tlb_write),
        .tlb_wdata (tlb_wdata),
        .xlate     (xlate)
    );

    fetch_port u_fetch_port (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc            (pc),
        .xlate         (xlate),
        .flush         (flush),
        .hold          (hold),
        .wb            (wb),
        .wb_dat        (wb_dat),
        .wb_ack        (wb_ack),
        .result        (result),
        .result_cached (result_cached),
        .advance       (advance)
    );

endmodule

// ==== test/prefetch_tb.sv ====
`timescale 1ns/1ps

module prefetch_tb;
    import fetch_pkg::*;
    import mmu_pkg::*;

    localparam logic [31:0] pattern = 32'h5A5A_5A5A;
    localparam int wait_limit = 50;
    localparam int max_lines  = 64;

    // one result as seen on the rising edge
    typedef struct packed {
        fetch_result_t res;
        logic          cached;
        wb_req_t       bus_ack;  // request at the last acked edge
        wb_req_t       bus_now;  // request while the result is valid
    } seen_t;

    logic          clk;
    logic          rst_n;
    redirect_t     redirect;
    logic          hold;
    logic          tlb_write;
    tlb_entry_t    tlb_wdata;
    wb_req_t       wb;
    logic [31:0]   wb_dat;
    logic          wb_ack;
    fetch_result_t result;
    logic          result_cached;

    logic [31:0]   cases_mem [max_lines*6];
    seen_t         result_q [$];
    wb_req_t       last_bus;
    logic [15:0]   lfsr;
    logic          slv_busy;    // slave has latched the open cycle
    logic [1:0]    slv_wait;
    logic [1:0]    delay_bits;

    prefetch_top #(
        .tlb_entries (4)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect      (redirect),
        .hold          (hold),
        .tlb_write     (tlb_write),
        .tlb_wdata     (tlb_wdata),
        .wb            (wb),
        .wb_dat        (wb_dat),
        .wb_ack        (wb_ack),
        .result        (result),
        .result_cached (result_cached)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        abort_run($sformatf("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic check_result(input fetch_result_t act, input fetch_result_t exp);
        if (act.pc !== exp.pc) report_mismatch("result.pc", exp.pc, act.pc);
        if (act.exc !== exp.exc) report_mismatch("result.exc", exp.exc, act.exc);
        if (act.instr !== exp.instr) report_mismatch("result.instr", exp.instr, act.instr);
    endtask

    task automatic check_bus(input wb_req_t act, input paddr_t exp_adr, input logic exp_open);
        if (act.cyc !== exp_open) report_mismatch("wb.cyc", exp_open, act.cyc);
        if (exp_open) begin
            if (act.stb !== 1'b1) report_mismatch("wb.stb", 1'b1, act.stb);
            if (act.adr !== exp_adr) report_mismatch("wb.adr", exp_adr, act.adr);
            if (act.sel !== 4'hF) report_mismatch("wb.sel", 4'hF, act.sel);
        end
    endtask

    task automatic check_cached(input logic act, input logic exp);
        if (act !== exp) report_mismatch("result_cached", exp, act);
    endtask

    // results are taken on the falling edge away from the monitor
    task automatic pop_result(output seen_t got);
        int waited;
        waited = 0;
        @(negedge clk);
        while (result_q.size() == 0) begin
            if (waited == wait_limit) abort_run("timed out after 50 cycles waiting for a result");
            @(negedge clk);
            waited++;
        end
        got = result_q.pop_front();
    endtask

    task automatic run_expect(input vaddr_t pc0, input paddr_t pa0, input logic cached,
                              input except_e exc, input int count);
        seen_t         got;
        fetch_result_t exp;
        int            i;
        for (i = 0; i < count; i++) begin
            pop_result(got);
            exp.pc    = pc0 + 4 * i;
            exp.exc   = exc;
            exp.instr = (exc == exc_none) ? ((pa0 + 4 * i) ^ pattern) : '0;
            check_result(got.res, exp);
            if (exc == exc_none) begin
                check_bus(got.bus_ack, pa0 + 4 * i, 1'b1);
                check_cached(got.cached, cached);
            end else begin
                check_bus(got.bus_now, '0, 1'b0);  // exception never opens a cycle
            end
        end
    endtask

    task automatic apply_refill(input tlb_entry_t ent);
        @(posedge clk);
        tlb_write <= 1'b1;
        tlb_wdata <= ent;
        @(posedge clk);
        tlb_write <= 1'b0;
    endtask

    task automatic apply_redirect(input redirect_t req, input logic on_bus);
        int waited;
        waited = 0;
        @(posedge clk);
        // first edge of a fresh cycle, so the in-flight word must be dropped
        while (on_bus && !(wb.cyc && !slv_busy && !wb_ack)) begin
            if (waited == wait_limit) abort_run("timed out after 50 cycles waiting for a bus cycle");
            @(posedge clk);
            waited++;
        end
        redirect <= req;
        @(posedge clk);
        redirect <= '0;
        @(posedge clk);
        @(negedge clk);
        result_q.delete();  // anything sampled so far is old path
    endtask

    task automatic hold_for(input int cycles);
        logic prev_cyc;
        int   i;
        @(posedge clk);
        hold <= 1'b1;
        @(posedge clk);
        prev_cyc = wb.cyc;  // a start on the hold edge itself is allowed
        for (i = 1; i < cycles; i++) begin
            @(posedge clk);
            if (wb.cyc && !prev_cyc) abort_run("a new bus cycle started while hold was high");
            prev_cyc = wb.cyc;
        end
        hold <= 1'b0;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (wb_ack) last_bus = wb;
            if (result.valid === 1'b1) result_q.push_back({result, result_cached, last_bus, wb});
        end
    end

    // slave latches the request, then waits 0 to 3 more cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            slv_busy <= 1'b0;
            slv_wait <= '0;
            lfsr     = 16'd5;
        end else if (wb_ack) begin
            wb_ack   <= 1'b0;
            slv_busy <= 1'b0;
        end else if (wb.cyc && wb.stb) begin
            if (!slv_busy) begin
                delay_bits[0] = lfsr[0];
                lfsr          = lfsr_next(lfsr);
                delay_bits[1] = lfsr[0];
                lfsr          = lfsr_next(lfsr);
                slv_busy <= 1'b1;
                slv_wait <= delay_bits;
            end else if (slv_wait == 2'd0) begin
                wb_ack <= 1'b1;
                wb_dat <= wb.adr ^ pattern;
            end else begin
                slv_wait <= slv_wait - 1'b1;
            end
        end
    end

    initial begin
        redirect_t   pend;
        int          base;
        logic [31:0] op;
        rst_n     = 1'b0;
        redirect  = '0;
        hold      = 1'b0;
        tlb_write = 1'b0;
        tlb_wdata = '0;
        wb_dat    = '0;
        wb_ack    = 1'b0;
        pend      = '0;
        $readmemh("test/fetch_cases.txt", cases_mem);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (base = 0; base < max_lines * 6; base += 6) begin
            op = cases_mem[base];
            if ($isunknown(op)) abort_run("case file is missing or has no end line");
            if (op == 32'd0) break;
            case (op)
                32'd1: apply_refill({cases_mem[base+1][19:0], cases_mem[base+2][19:0],
                                     cases_mem[base+3][0], cases_mem[base+4][0]});
                32'd2: begin
                    case (cases_mem[base+1][1:0])
                        2'd0: pend.exc        = {1'b1, cases_mem[base+2]};
                        2'd1: pend.eret       = {1'b1, cases_mem[base+2]};
                        2'd2: pend.refetch    = {1'b1, cases_mem[base+2]};
                        default: pend.correction = {1'b1, cases_mem[base+2]};
                    endcase
                    if (!cases_mem[base+3][0]) begin  // last source of this cycle
                        apply_redirect(pend, cases_mem[base+4][0]);
                        pend = '0;
                    end
                end
                32'd3: hold_for(int'(cases_mem[base+1]));
                32'd4: run_expect(cases_mem[base+1], cases_mem[base+2], cases_mem[base+3][0],
                                  except_e'(cases_mem[base+4][1:0]), int'(cases_mem[base+5]));
                default: abort_run("unknown command in the case file");
            endcase
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== prefetch_top.f ====
hw/fetch_pkg.sv
hw/mmu_pkg.sv
hw/pc_gen.sv
hw/itlb.sv
hw/fetch_port.sv
hw/prefetch_top.sv
test/prefetch_tb.sv

// ==== test/fetch_cases.txt ====
// columns: op a b c d e, all hex, one command per line
// 1 refill vpn pfn valid cached | 2 redirect src(0 exc 1 eret 2 refetch 3 corr) target join on_bus
// 3 hold cycles | 4 expect pc paddr(0 = none) cached exc count | 0 end
4 BFC00000 1FC00000 0 0 4   // boot stream in kseg1
3 0C 0 0 0 0
4 BFC00010 1FC00010 0 0 4   // picks up right after the hold
2 0 BFC00180 1 0 0          // all four sources in one cycle
2 1 80001000 1 0 0
2 2 A0002000 1 0 0
2 3 80003000 0 1 0
4 BFC00180 1FC00180 0 0 2
2 1 80001000 1 0 0          // eret beats correction
2 3 80003000 0 1 0
4 80001000 00001000 1 0 2
2 2 A0002000 1 0 0          // refetch beats correction
2 3 80003000 0 1 0
4 A0002000 00002000 0 0 2
2 3 80003000 0 1 0
4 80003000 00003000 1 0 2
2 3 00400000 0 1 0          // mapped page, empty tlb
4 00400000 00000000 0 2 2
1 00400 00123 1 1 0
2 3 00400000 0 0 0
4 00400000 00123000 1 0 3
1 00400 00123 0 1 0         // same vpn, now invalid
2 3 00400000 0 0 0
4 00400000 00000000 0 3 2
1 00400 00123 1 0 0
2 3 00400002 0 0 0          // misaligned with a matching entry
4 00400002 00000000 0 1 2
2 3 00400010 0 0 0
4 00400010 00123010 0 0 2
3 0A 0 0 0 0
4 00400018 00123018 0 0 8
0 0 0 0 0 0
